//--- rtl/cache_meta_macros.svh
`ifndef CACHE_META_MACROS_SVH
`define CACHE_META_MACROS_SVH

// Cache geometry
`define CM_SETS          16
`define CM_SET_W         4
`define CM_WAYS          4

// Per-way metadata layout, age in the upper half
`define CM_AGE_W         4
`define CM_META_W        8

`define CM_ADDR_W        26
`define CM_MSHR_ENTRIES  4

`endif

//--- rtl/cache_meta_pkg.sv
`default_nettype none

`include "cache_meta_macros.svh"

package cache_meta_pkg;

    // One-hot way state, bit 3 marks an outstanding fill
    typedef enum logic [`CM_META_W-`CM_AGE_W-1:0] {
        ST_INVALID  = 4'b0001,
        ST_SHARED   = 4'b0010,
        ST_MODIFIED = 4'b0100,
        ST_PENDING  = 4'b1000
    } pmsi_state_e;

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_LOAD  = 3'd1,
        OP_STORE = 3'd2,
        OP_FILL  = 3'd3,
        OP_INVAL = 3'd4
    } cache_op_e;

endpackage

`default_nettype wire

//--- rtl/victim_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_meta_macros.svh"

module victim_select (
    input  logic [`CM_WAYS*`CM_AGE_W-1:0] ages,
    input  logic [`CM_WAYS*`CM_AGE_W-1:0] states,
    output logic [`CM_WAYS-1:0]           victim,
    output logic                          none_free
);

    localparam int ST_W = `CM_META_W - `CM_AGE_W;

    logic [`CM_AGE_W-1:0] age [`CM_WAYS];
    logic [`CM_WAYS-1:0]  pending;
    logic [`CM_WAYS-1:0]  invalid;
    logic [`CM_WAYS-1:0]  oldest;
    logic [`CM_WAYS-1:0]  first_free;
    logic [`CM_AGE_W-1:0] best_age;
    logic                 found;

    for (genvar g = 0; g < `CM_WAYS; g++) begin : g_split
        assign age[g]     = ages[g*`CM_AGE_W +: `CM_AGE_W];
        assign pending[g] = states[g*ST_W +: ST_W] == cache_meta_pkg::ST_PENDING;
        assign invalid[g] = states[g*ST_W +: ST_W] == cache_meta_pkg::ST_INVALID;
    end

    always_comb begin
        found      = 1'b0;
        best_age   = '0;
        oldest     = '0;
        first_free = '0;
        for (int i = 0; i < `CM_WAYS; i++) begin
            if (!pending[i] && (!found || age[i] >= best_age)) begin // Ties go to higher way
                found     = 1'b1;
                best_age  = age[i];
                oldest    = '0;
                oldest[i] = 1'b1;
            end
        end
        for (int i = `CM_WAYS-1; i >= 0; i--) begin
            if (invalid[i]) begin // Lowest free way wins
                first_free    = '0;
                first_free[i] = 1'b1;
            end
        end
    end

    assign victim    = (|first_free) ? first_free : oldest;
    assign none_free = ~found;

endmodule

`default_nettype wire

//--- rtl/pmsi_next_state.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_meta_macros.svh"

// A load on the target way here means a fetch is launched for it
module pmsi_next_state (
    input  cache_meta_pkg::cache_op_e                         op,
    input  logic [`CM_WAYS-1:0]                               target,
    input  logic [`CM_WAYS*(`CM_META_W-`CM_AGE_W)-1:0]        states_in,
    output logic [`CM_WAYS*(`CM_META_W-`CM_AGE_W)-1:0]        states_out,
    output logic                                              wb_to_l2
);

    localparam int ST_W = `CM_META_W - `CM_AGE_W;

    logic [ST_W-1:0] cur;
    logic [ST_W-1:0] nxt;
    logic            dirty;

    always_comb begin
        states_out = states_in;
        wb_to_l2   = 1'b0;
        cur        = '0;
        nxt        = '0;
        dirty      = 1'b0;
        for (int i = 0; i < `CM_WAYS; i++) begin
            if (target[i]) begin
                cur   = states_in[i*ST_W +: ST_W];
                nxt   = cur;
                dirty = cur == cache_meta_pkg::ST_MODIFIED;
                case (op)
                    cache_meta_pkg::OP_STORE: nxt = cache_meta_pkg::ST_MODIFIED;
                    cache_meta_pkg::OP_LOAD: begin
                        nxt      = cache_meta_pkg::ST_PENDING; // Victim waits for fill
                        wb_to_l2 = dirty;
                    end
                    cache_meta_pkg::OP_FILL: nxt = cache_meta_pkg::ST_SHARED;
                    cache_meta_pkg::OP_INVAL: begin
                        nxt      = cache_meta_pkg::ST_INVALID;
                        wb_to_l2 = dirty;
                    end
                    default: nxt = cur;
                endcase
                states_out[i*ST_W +: ST_W] = nxt;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/meta_next.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_meta_macros.svh"

module meta_next (
    input  logic                              req_valid,
    input  cache_meta_pkg::cache_op_e         op,
    input  logic [`CM_WAYS-1:0]               hits,
    input  logic                              mshr_hit,
    input  logic                              mshr_full,
    input  logic [`CM_WAYS*`CM_META_W-1:0]    meta_rd,
    output logic [`CM_WAYS*`CM_META_W-1:0]    meta_wr,
    output logic                              meta_we,
    output logic [`CM_WAYS-1:0]               way,
    output logic                              tag_alloc,
    output logic                              mshr_alloc,
    output logic                              mshr_free,
    output logic                              pending_stall,
    output logic                              wb_to_l2
);

    localparam int ST_W = `CM_META_W - `CM_AGE_W;

    logic [`CM_WAYS*`CM_AGE_W-1:0] ages;
    logic [`CM_WAYS*ST_W-1:0]      states;
    logic [`CM_WAYS*ST_W-1:0]      states_nxt;
    logic [`CM_WAYS-1:0]           pending;
    logic [`CM_WAYS-1:0]           victim;
    logic                          none_free;
    logic                          ld_st, hit, hit_pend, ld_st_hit, alloc, fill, inval;
    cache_meta_pkg::cache_op_e     pmsi_op;

    for (genvar g = 0; g < `CM_WAYS; g++) begin : g_way
        logic [`CM_AGE_W-1:0] age;
        logic [`CM_AGE_W-1:0] age_nxt;
        assign age = meta_rd[g*`CM_META_W+ST_W +: `CM_AGE_W];
        assign ages[g*`CM_AGE_W +: `CM_AGE_W] = age;
        assign states[g*ST_W +: ST_W] = meta_rd[g*`CM_META_W +: ST_W];
        assign pending[g] = meta_rd[g*`CM_META_W + ST_W - 1];
        assign age_nxt = !(ld_st_hit || alloc) ? age
                       : way[g]                ? '0
                       : (&age)                ? age // Saturate at 15
                       :                         age + 1'b1;
        assign meta_wr[g*`CM_META_W +: `CM_META_W] = {age_nxt, states_nxt[g*ST_W +: ST_W]};
    end

    assign ld_st     = req_valid && (op == cache_meta_pkg::OP_LOAD ||
                                     op == cache_meta_pkg::OP_STORE);
    assign hit       = |hits;
    assign hit_pend  = |(hits & pending);
    assign ld_st_hit = ld_st && hit && !hit_pend;
    assign alloc     = ld_st && !hit && !mshr_hit && !mshr_full && !none_free;
    assign fill      = req_valid && op == cache_meta_pkg::OP_FILL && hit_pend;
    assign inval     = req_valid && op == cache_meta_pkg::OP_INVAL && hit;

    assign pending_stall = ld_st && (hit ? hit_pend : (!mshr_hit && (mshr_full || none_free)));
    assign way           = (ld_st_hit || fill || inval) ? hits : alloc ? victim : '0;
    assign tag_alloc     = alloc;
    assign mshr_alloc    = alloc;
    assign mshr_free     = fill;
    assign meta_we       = ld_st_hit || alloc || fill || inval;

    always_comb begin
        if (alloc)
            pmsi_op = cache_meta_pkg::OP_LOAD; // Miss launches a fetch
        else if (ld_st_hit && op == cache_meta_pkg::OP_STORE)
            pmsi_op = cache_meta_pkg::OP_STORE;
        else if (fill)
            pmsi_op = cache_meta_pkg::OP_FILL;
        else if (inval)
            pmsi_op = cache_meta_pkg::OP_INVAL;
        else
            pmsi_op = cache_meta_pkg::OP_NONE;
    end

    victim_select u_victim (
        .ages      (ages),
        .states    (states),
        .victim    (victim),
        .none_free (none_free)
    );

    pmsi_next_state u_pmsi (
        .op         (pmsi_op),
        .target     (way),
        .states_in  (states),
        .states_out (states_nxt),
        .wb_to_l2   (wb_to_l2)
    );

endmodule

`default_nettype wire

//--- rtl/meta_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_meta_macros.svh"

module meta_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`CM_SET_W-1:0]           set_index,
    input  logic                           meta_we,
    input  logic [`CM_WAYS*`CM_META_W-1:0] meta_wr,
    output logic [`CM_WAYS*`CM_META_W-1:0] meta_rd
);

    localparam int WORD_W = `CM_WAYS * `CM_META_W;

    // Way n starts invalid with age n
    function automatic logic [WORD_W-1:0] init_word();
        logic [WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < `CM_WAYS; i++) begin
            w[i*`CM_META_W +: `CM_META_W] = {i[`CM_AGE_W-1:0], cache_meta_pkg::ST_INVALID};
        end
        return w;
    endfunction

    logic [WORD_W-1:0] mem [`CM_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CM_SETS; s++) begin
                mem[s] <= init_word();
            end
        end else if (meta_we) begin
            mem[set_index] <= meta_wr;
        end
    end

    assign meta_rd = mem[set_index]; // Async read

endmodule

`default_nettype wire

//--- rtl/mshr_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_meta_macros.svh"

module mshr_table #(
    parameter int ENTRIES = `CM_MSHR_ENTRIES
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`CM_ADDR_W-1:0] line_addr,
    input  logic                  alloc,
    input  logic                  free,
    output logic                  mshr_hit,
    output logic                  mshr_full
);

    logic [ENTRIES-1:0]    valid;
    logic [`CM_ADDR_W-1:0] addr [ENTRIES];
    logic [ENTRIES-1:0]    match;
    logic [ENTRIES-1:0]    alloc_sel;

    always_comb begin
        alloc_sel = '0;
        for (int i = ENTRIES-1; i >= 0; i--) begin
            if (!valid[i]) begin // Lowest free entry
                alloc_sel    = '0;
                alloc_sel[i] = 1'b1;
            end
        end
    end

    for (genvar g = 0; g < ENTRIES; g++) begin : g_entry
        assign match[g] = valid[g] && addr[g] == line_addr;

        always_ff @(posedge clk) begin
            if (rst) begin
                valid[g] <= 1'b0;
            end else if (alloc && alloc_sel[g]) begin
                valid[g] <= 1'b1;
            end else if (free && match[g]) begin
                valid[g] <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (alloc && alloc_sel[g])
                addr[g] <= line_addr;
        end
    end

    assign mshr_hit  = |match;
    assign mshr_full = &valid;

endmodule

`default_nettype wire

//--- rtl/cache_meta_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_meta_macros.svh"

module cache_meta_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  cache_meta_pkg::cache_op_e op,
    input  logic [`CM_SET_W-1:0]      set_index,
    input  logic [`CM_ADDR_W-1:0]     line_addr,
    input  logic [`CM_WAYS-1:0]       hits,
    output logic                      resp_valid,
    output logic [`CM_WAYS-1:0]       resp_way,
    output logic                      resp_tag_alloc,
    output logic                      resp_mshr_alloc,
    output logic                      resp_pending_stall,
    output logic                      resp_wb_to_l2
);

    logic [`CM_WAYS*`CM_META_W-1:0] meta_rd;
    logic [`CM_WAYS*`CM_META_W-1:0] meta_wr;
    logic                           meta_we;
    logic [`CM_WAYS-1:0]            way;
    logic                           tag_alloc, mshr_alloc, mshr_free;
    logic                           pending_stall, wb_to_l2;
    logic                           mshr_hit, mshr_full;

    meta_array u_array (
        .clk       (clk),
        .rst       (rst),
        .set_index (set_index),
        .meta_we   (meta_we),
        .meta_wr   (meta_wr),
        .meta_rd   (meta_rd)
    );

    meta_next u_next (
        .req_valid     (req_valid),
        .op            (op),
        .hits          (hits),
        .mshr_hit      (mshr_hit),
        .mshr_full     (mshr_full),
        .meta_rd       (meta_rd),
        .meta_wr       (meta_wr),
        .meta_we       (meta_we),
        .way           (way),
        .tag_alloc     (tag_alloc),
        .mshr_alloc    (mshr_alloc),
        .mshr_free     (mshr_free),
        .pending_stall (pending_stall),
        .wb_to_l2      (wb_to_l2)
    );

    mshr_table #(
        .ENTRIES (`CM_MSHR_ENTRIES)
    ) u_mshr (
        .clk       (clk),
        .rst       (rst),
        .line_addr (line_addr),
        .alloc     (mshr_alloc),
        .free      (mshr_free),
        .mshr_hit  (mshr_hit),
        .mshr_full (mshr_full)
    );

    // Single response stage
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid         <= 1'b0;
            resp_way           <= '0;
            resp_tag_alloc     <= 1'b0;
            resp_mshr_alloc    <= 1'b0;
            resp_pending_stall <= 1'b0;
            resp_wb_to_l2      <= 1'b0;
        end else begin
            resp_valid         <= req_valid;
            resp_way           <= way;
            resp_tag_alloc     <= tag_alloc;
            resp_mshr_alloc    <= mshr_alloc;
            resp_pending_stall <= pending_stall;
            resp_wb_to_l2      <= wb_to_l2;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb/cache_meta_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_meta_macros.svh"

module cache_meta_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      exp_strobe,
    input  int                        exp_test,
    input  cache_meta_pkg::cache_op_e exp_op,
    input  logic [`CM_WAYS-1:0]       exp_way,
    input  logic                      exp_tag_alloc,
    input  logic                      exp_mshr_alloc,
    input  logic                      exp_stall,
    input  logic                      exp_wb,
    input  logic                      resp_valid,
    input  logic [`CM_WAYS-1:0]       resp_way,
    input  logic                      resp_tag_alloc,
    input  logic                      resp_mshr_alloc,
    input  logic                      resp_pending_stall,
    input  logic                      resp_wb_to_l2,
    input  logic                      done,
    output logic                      report_done,
    output int                        pass_tests,
    output int                        fail_tests,
    output int                        error_count
);

    logic                      pend;
    int                        pend_test;
    cache_meta_pkg::cache_op_e pend_op;
    logic [`CM_WAYS-1:0]       pend_way;
    logic                      pend_tag_alloc, pend_mshr_alloc, pend_stall, pend_wb;
    logic                      started;
    int                        cur_test;
    int                        cur_errors;
    int                        cur_checks;

    // Expected values line up with the response one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else begin
            pend <= exp_strobe;
            if (exp_strobe) begin
                pend_test       <= exp_test;
                pend_op         <= exp_op;
                pend_way        <= exp_way;
                pend_tag_alloc  <= exp_tag_alloc;
                pend_mshr_alloc <= exp_mshr_alloc;
                pend_stall      <= exp_stall;
                pend_wb         <= exp_wb;
            end
        end
    end

    task automatic check_field(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: test %0d %s, %s expected %h got %h",
                     $time, pend_test, pend_op.name(), name, exp, got);
            cur_errors++;
            error_count++;
        end
    endtask

    task automatic close_test();
        if (cur_errors == 0) begin
            $display("Test %0d passed, %0d requests", cur_test, cur_checks);
            pass_tests++;
        end else begin
            $display("Test %0d FAILED, %0d field errors in %0d requests",
                     cur_test, cur_errors, cur_checks);
            fail_tests++;
        end
    endtask

    // Sample on the falling edge away from the register updates
    always @(negedge clk) begin
        if (rst) begin
            started     = 1'b0;
            report_done = 1'b0;
            pass_tests  = 0;
            fail_tests  = 0;
            error_count = 0;
        end else if (pend) begin
            if (started && pend_test != cur_test)
                close_test();
            if (!started || pend_test != cur_test) begin
                started    = 1'b1;
                cur_test   = pend_test;
                cur_errors = 0;
                cur_checks = 0;
            end
            check_field("resp_valid", {3'b000, resp_valid}, 4'h1);
            check_field("resp_way", resp_way, pend_way);
            check_field("resp_tag_alloc", {3'b000, resp_tag_alloc}, {3'b000, pend_tag_alloc});
            check_field("resp_mshr_alloc", {3'b000, resp_mshr_alloc}, {3'b000, pend_mshr_alloc});
            check_field("resp_pending_stall", {3'b000, resp_pending_stall}, {3'b000, pend_stall});
            check_field("resp_wb_to_l2", {3'b000, resp_wb_to_l2}, {3'b000, pend_wb});
            cur_checks++;
        end else begin
            if (resp_valid !== 1'b0) begin // No request one edge back
                $display("[ERROR] %0t ns: resp_valid is %b with no request", $time, resp_valid);
                error_count++;
                if (started)
                    cur_errors++;
            end
            if (done && !report_done) begin
                if (started)
                    close_test();
                $display("Tests passed: %0d, tests failed: %0d, field errors: %0d",
                         pass_tests, fail_tests, error_count);
                report_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/cache_meta_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_meta_macros.svh"

module cache_meta_tb;

    localparam int    RESET_CYCLES = 2;
    localparam int    MAX_LINES    = 256;
    localparam int    WAIT_LIMIT   = 20;
    localparam string PATTERN_FILE = "tb/cache_meta_patterns.txt";

    logic                      clk, rst, req_valid;
    cache_meta_pkg::cache_op_e op;
    logic [`CM_SET_W-1:0]      set_index;
    logic [`CM_ADDR_W-1:0]     line_addr;
    logic [`CM_WAYS-1:0]       hits;
    logic                      resp_valid, resp_tag_alloc, resp_mshr_alloc;
    logic                      resp_pending_stall, resp_wb_to_l2;
    logic [`CM_WAYS-1:0]       resp_way;

    logic                      exp_strobe, exp_tag_alloc, exp_mshr_alloc, exp_stall, exp_wb;
    int                        exp_test;
    cache_meta_pkg::cache_op_e exp_op;
    logic [`CM_WAYS-1:0]       exp_way;
    logic                      done, report_done;
    int                        pass_tests, fail_tests, error_count;
    logic                      trouble; // Timeout or unusable pattern file

    tb_clock_gen #(.PERIOD_NS(100)) clk_gen_i (.clk(clk));

    cache_meta_top dut_i (
        .clk                (clk),
        .rst                (rst),
        .req_valid          (req_valid),
        .op                 (op),
        .set_index          (set_index),
        .line_addr          (line_addr),
        .hits               (hits),
        .resp_valid         (resp_valid),
        .resp_way           (resp_way),
        .resp_tag_alloc     (resp_tag_alloc),
        .resp_mshr_alloc    (resp_mshr_alloc),
        .resp_pending_stall (resp_pending_stall),
        .resp_wb_to_l2      (resp_wb_to_l2)
    );

    cache_meta_checker checker_i (
        .clk (clk), .rst (rst),
        .exp_strobe (exp_strobe), .exp_test (exp_test), .exp_op (exp_op),
        .exp_way (exp_way), .exp_tag_alloc (exp_tag_alloc),
        .exp_mshr_alloc (exp_mshr_alloc), .exp_stall (exp_stall), .exp_wb (exp_wb),
        .resp_valid (resp_valid), .resp_way (resp_way),
        .resp_tag_alloc (resp_tag_alloc), .resp_mshr_alloc (resp_mshr_alloc),
        .resp_pending_stall (resp_pending_stall), .resp_wb_to_l2 (resp_wb_to_l2),
        .done (done), .report_done (report_done),
        .pass_tests (pass_tests), .fail_tests (fail_tests), .error_count (error_count)
    );

    task automatic wait_reset_release();
        int n;
        n = 0;
        while ((rst || resp_valid !== 1'b0) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst || resp_valid !== 1'b0) begin
            $display("Timed out waiting for the DUT to leave reset");
            trouble = 1'b1;
        end
    endtask

    task automatic run_patterns();
        int                    fd, n, lines, t;
        string                 text;
        logic [2:0]            p_op;
        logic [`CM_SET_W-1:0]  p_set;
        logic [`CM_ADDR_W-1:0] p_addr;
        logic [`CM_WAYS-1:0]   p_hits, p_way;
        logic                  p_ta, p_ma, p_st, p_wb;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            trouble = 1'b1;
            return;
        end
        lines = 0;
        while (!$feof(fd) && lines < MAX_LINES) begin
            text = "";
            n = $fgets(text, fd);
            lines++;
            if (text.len() < 2 || text[0] == "#")
                continue; // Blank or column note
            n = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h",
                        t, p_op, p_set, p_addr, p_hits, p_way, p_ta, p_ma, p_st, p_wb);
            if (n != 10) begin
                $display("Pattern line %0d could not be parsed", lines);
                trouble = 1'b1;
                continue;
            end
            @(posedge clk);
            req_valid      <= 1'b1;
            op             <= cache_meta_pkg::cache_op_e'(p_op);
            set_index      <= p_set;
            line_addr      <= p_addr;
            hits           <= p_hits;
            exp_strobe     <= 1'b1;
            exp_test       <= t;
            exp_op         <= cache_meta_pkg::cache_op_e'(p_op);
            exp_way        <= p_way;
            exp_tag_alloc  <= p_ta;
            exp_mshr_alloc <= p_ma;
            exp_stall      <= p_st;
            exp_wb         <= p_wb;
        end
        if (!$feof(fd)) begin
            $display("Gave up reading the pattern file after %0d lines", MAX_LINES);
            trouble = 1'b1;
        end
        $fclose(fd);
        @(posedge clk);
        req_valid  <= 1'b0;
        op         <= cache_meta_pkg::OP_NONE;
        hits       <= '0;
        exp_strobe <= 1'b0;
    endtask

    task automatic wait_report();
        int n;
        n = 0;
        while (report_done !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (report_done !== 1'b1) begin
            $display("Timed out waiting for the checker to report");
            trouble = 1'b1;
        end
    endtask

    initial begin
        trouble        = 1'b0;
        rst            = 1'b1;
        req_valid      = 1'b0;
        op             = cache_meta_pkg::OP_NONE;
        set_index      = '0;
        line_addr      = '0;
        hits           = '0;
        exp_strobe     = 1'b0;
        exp_test       = 0;
        exp_op         = cache_meta_pkg::OP_NONE;
        exp_way        = '0;
        exp_tag_alloc  = 1'b0;
        exp_mshr_alloc = 1'b0;
        exp_stall      = 1'b0;
        exp_wb         = 1'b0;
        done           = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        wait_reset_release();
        if (!trouble)
            run_patterns();
        done <= 1'b1;
        wait_report();
        if (!trouble && pass_tests > 0 && fail_tests == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/cache_meta_pkg.sv
rtl/victim_select.sv
rtl/pmsi_next_state.sv
rtl/meta_next.sv
rtl/meta_array.sv
rtl/mshr_table.sv
rtl/cache_meta_top.sv
tb/tb_clock_gen.sv
tb/cache_meta_checker.sv
tb/cache_meta_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= cache_meta_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/cache_meta_patterns.txt
# test op set line_addr hits  way tag_alloc mshr_alloc pending_stall wb_to_l2
# op 1 load, 2 store, 3 fill, 4 inval; test is decimal, the rest hex
1 1 3 0000100 0  1 1 1 0 0
1 1 3 0000101 0  2 1 1 0 0
1 2 3 0000102 0  4 1 1 0 0
1 1 3 0000103 0  8 1 1 0 0
2 1 3 0000104 0  0 0 0 1 0
2 1 3 0000101 0  0 0 0 0 0
2 1 3 0000100 1  0 0 0 1 0
3 3 3 0000100 1  1 0 0 0 0
3 3 3 0000101 2  2 0 0 0 0
3 3 3 0000102 4  4 0 0 0 0
3 3 3 0000103 8  8 0 0 0 0
3 1 3 0000101 2  2 0 0 0 0
3 2 3 0000102 4  4 0 0 0 0
4 1 3 0000105 0  1 1 1 0 0
4 3 3 0000105 1  1 0 0 0 0
4 1 3 0000103 8  8 0 0 0 0
4 1 3 0000101 2  2 0 0 0 0
4 1 3 0000105 1  1 0 0 0 0
4 1 3 0000106 0  4 1 1 0 1
4 3 3 0000106 4  4 0 0 0 0
5 2 3 0000101 2  2 0 0 0 0
5 4 3 0000101 2  2 0 0 0 1
5 4 3 0000108 0  0 0 0 0 0
5 1 3 0000107 0  2 1 1 0 0
5 1 5 0000200 0  1 1 1 0 0
